//--- sources.f
logic/display_pkg.sv
logic/pixel_ram_bank.sv
logic/display_buffers.sv
logic/display_scan.sv
logic/display_subsystem.sv
tb/display_tb.sv

//--- tb/display_tb.sv
/*
 * Testbench for the double-buffered frame store. Random pixel writes and swap
 * requests go in, every valid scanned pixel is compared with a two-buffer model
 */

`timescale 1ns/1ps

module display_tb;

localparam int FRAME_WIDTH = 32;
localparam int FRAME_HEIGHT = 16;
localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
localparam int PIXEL_ADDRESS_WIDTH = 9;
localparam int BLANK_CYCLES = 20;
localparam int CLOCK_PERIOD = 8;
localparam int NUM_FRAMES = 12;
localparam int WRITE_WINDOW = 380;
localparam int SWAP_CYCLE = 400;
localparam int WATCHDOG_NS = 2 * NUM_FRAMES * (FRAME_PIXELS + BLANK_CYCLES) * CLOCK_PERIOD;

logic clock_in;
logic reset_n_in;
logic pixel_write_enable;
logic [PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address;
logic [display_pkg::PIXEL_BITS-1:0] pixel_write_data;
logic swap_request;
logic scan_enable;
logic [display_pkg::PIXEL_BITS-1:0] pixel_data;
logic pixel_valid;
logic frame_start;

// Model of both buffers, index 0 is buffer A
logic [display_pkg::PIXEL_BITS-1:0] model_pixels [2][FRAME_PIXELS];
bit pixel_written [2][FRAME_PIXELS];
int front_index = 0;
bit swap_requested = 0;

int error_count = 0;
int frame_count = 0;
int frame_cycle = 0;
int read_pointer = 0;
int pixels_seen = 0;
int pixels_compared = 0;
int blank_cycles_seen = 0;
int fill_address = 0;
logic [31:0] rng_state = 32'd19;

display_subsystem #(
    .FRAME_WIDTH(FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT),
    .PIXEL_ADDRESS_WIDTH(PIXEL_ADDRESS_WIDTH),
    .BLANK_CYCLES(BLANK_CYCLES)
) UUT (
    .clock_in(clock_in),
    .reset_n_in(reset_n_in),
    .pixel_write_enable(pixel_write_enable),
    .pixel_write_address(pixel_write_address),
    .pixel_write_data(pixel_write_data),
    .swap_request(swap_request),
    .scan_enable(scan_enable),
    .pixel_data(pixel_data),
    .pixel_valid(pixel_valid),
    .frame_start(frame_start)
);

initial begin
    clock_in = 0;
    forever #(CLOCK_PERIOD / 2) clock_in = ~clock_in;
end

function automatic logic [31:0] xorshift32(input logic [31:0] value);
    value = value ^ (value << 13);
    value = value ^ (value >> 17);
    value = value ^ (value << 5);
    return value;
endfunction

function automatic logic [31:0] draw_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task automatic idle_cycle();
    @(posedge clock_in);
    pixel_write_enable <= 0;
endtask

// Writes always land in the buffer that is off screen
task automatic write_pixel(input logic [PIXEL_ADDRESS_WIDTH-1:0] address,
                           input logic [display_pkg::PIXEL_BITS-1:0] data);
    @(posedge clock_in);
    pixel_write_enable <= 1;
    pixel_write_address <= address;
    pixel_write_data <= data;
    model_pixels[1 - front_index][address] = data;
    pixel_written[1 - front_index][address] = 1;
endtask

task automatic wait_frame(input int frame);
    while (frame_count < frame) @(posedge clock_in);
endtask

task automatic wait_until_cycle(input int cycle);
    while (frame_cycle < cycle) @(posedge clock_in);
endtask

task automatic fill_back_buffer();
    while (frame_cycle < WRITE_WINDOW && fill_address < FRAME_PIXELS) begin
        write_pixel(fill_address[PIXEL_ADDRESS_WIDTH-1:0], draw_random() >> 28);
        fill_address++;
    end
    idle_cycle();
endtask

task automatic random_writes();
    logic [31:0] r;
    logic [PIXEL_ADDRESS_WIDTH-4:0] word;
    int burst_length;
    while (frame_cycle < WRITE_WINDOW) begin
        r = draw_random();
        if (r[1:0] == 2'd0) begin
            // Back-to-back writes into one word
            word = r[13:8];
            burst_length = 2 + (r[4:2] % 7);
            for (int k = 0; k < burst_length; k++) begin
                r = draw_random();
                write_pixel({word, r[2:0]}, r[7:4]);
            end
        end else begin
            write_pixel(r[16:8], r[23:20]);
        end
        repeat (r[29:28]) idle_cycle();
    end
    idle_cycle();
endtask

// Each pulse is one rising edge, the model swaps once per frame at most
task automatic pulse_swap(input int pulses);
    wait_until_cycle(SWAP_CYCLE);
    for (int i = 0; i < pulses; i++) begin
        @(posedge clock_in);
        swap_request <= 1;
        swap_requested = 1;
        repeat (3) @(posedge clock_in);
        swap_request <= 0;
        repeat (2) @(posedge clock_in);
    end
endtask

always @(negedge clock_in) begin
    if (reset_n_in) begin
        if (frame_count == 0 && !frame_start) begin
            if (pixel_valid) begin
                $display("Error: %0d ns pixel_valid high before the first frame", $time);
                error_count++;
            end
            blank_cycles_seen++;
        end

        if (frame_start) begin
            if (frame_count == 0 && blank_cycles_seen != BLANK_CYCLES) begin
                $display("Error: %0d ns first frame after %0d blank cycles, expected %0d",
                         $time, blank_cycles_seen, BLANK_CYCLES);
                error_count++;
            end
            if (swap_requested) begin
                front_index = 1 - front_index;
                swap_requested = 0;
            end
            frame_count++;
            frame_cycle = 0;
            read_pointer = 0;
        end else begin
            frame_cycle++;
        end

        if (pixel_valid) begin
            // Pixel n of a frame is due two cycles after address n
            if (frame_cycle != read_pointer + 2) begin
                $display("Error: %0d ns pixel %0d valid at frame cycle %0d, expected %0d",
                         $time, read_pointer, frame_cycle, read_pointer + 2);
                error_count++;
            end
            if (read_pointer >= FRAME_PIXELS) begin
                $display("Error: %0d ns more than %0d valid pixels in one frame",
                         $time, FRAME_PIXELS);
                error_count++;
            end else if (pixel_written[front_index][read_pointer]) begin
                if (pixel_data !== model_pixels[front_index][read_pointer]) begin
                    $display("Error: %0d ns pixel %0d expected %h got %h", $time,
                             read_pointer, model_pixels[front_index][read_pointer], pixel_data);
                    error_count++;
                end
                pixels_compared++;
            end
            read_pointer++;
            pixels_seen++;
        end
    end
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout: no end of test after %0d ns, %0d errors so far", WATCHDOG_NS, error_count);
    $display("TB FAILED");
    $finish;
end

initial begin
    reset_n_in = 0;
    pixel_write_enable = 0;
    pixel_write_address = '0;
    pixel_write_data = '0;
    swap_request = 0;
    scan_enable = 1;
    repeat (5) @(posedge clock_in);
    reset_n_in <= 1;

    for (int frame = 1; frame <= NUM_FRAMES; frame++) begin
        wait_frame(frame);
        case (frame)
            1: fill_back_buffer();
            2: begin
                fill_back_buffer();
                pulse_swap(1);
            end
            3: begin
                fill_address = 0;
                fill_back_buffer();
            end
            4: begin
                fill_back_buffer();
                pulse_swap(1);
            end
            5: begin
                // Request stays high through frame 6
                random_writes();
                wait_until_cycle(SWAP_CYCLE);
                swap_request <= 1;
                swap_requested = 1;
            end
            6: random_writes();
            7: begin
                swap_request <= 0;
                random_writes();
            end
            8: begin
                random_writes();
                pulse_swap(2);
            end
            NUM_FRAMES: scan_enable <= 0;
            default: begin
                random_writes();
                if (frame == NUM_FRAMES - 1 || draw_random() % 2 == 0) begin
                    pulse_swap(1);
                end
            end
        endcase
    end

    // Scanner is held off now, no further frame may start
    wait_until_cycle(FRAME_PIXELS + BLANK_CYCLES + 16);
    if (frame_count != NUM_FRAMES) begin
        $display("Error: %0d ns saw %0d frames, expected %0d", $time, frame_count, NUM_FRAMES);
        error_count++;
    end
    if (pixels_seen != NUM_FRAMES * FRAME_PIXELS) begin
        $display("Error: %0d ns saw %0d valid pixels, expected %0d", $time, pixels_seen,
                 NUM_FRAMES * FRAME_PIXELS);
        error_count++;
    end

    $display("Result: %0d errors over %0d frames, %0d pixels compared", error_count,
             frame_count, pixels_compared);
    if (error_count == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

//--- logic/display_subsystem.sv
/*
 * Display frame store top level. Ties the raster scanner to the double buffer
 * and sets the frame geometry for both
 */

`timescale 1ns/1ps

module display_subsystem #(
    parameter int FRAME_WIDTH = 640,
    parameter int FRAME_HEIGHT = 400,
    parameter int PIXEL_ADDRESS_WIDTH = 18,
    parameter int BLANK_CYCLES = 1000
) (
    input logic clock_in,
    input logic reset_n_in,

    input logic pixel_write_enable,
    input logic [PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address,
    input logic [display_pkg::PIXEL_BITS-1:0] pixel_write_data,

    input logic swap_request,
    input logic scan_enable,

    output logic [display_pkg::PIXEL_BITS-1:0] pixel_data,
    output logic pixel_valid,
    output logic frame_start
);

logic [PIXEL_ADDRESS_WIDTH-1:0] read_address;
logic read_enable;

display_scan #(
    .FRAME_WIDTH(FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT),
    .PIXEL_ADDRESS_WIDTH(PIXEL_ADDRESS_WIDTH),
    .BLANK_CYCLES(BLANK_CYCLES)
) display_scan (
    .clock_in(clock_in),
    .reset_n_in(reset_n_in),
    .scan_enable(scan_enable),
    .read_address(read_address),
    .read_enable(read_enable),
    .frame_start(frame_start)
);

display_buffers #(
    .PIXEL_ADDRESS_WIDTH(PIXEL_ADDRESS_WIDTH)
) display_buffers (
    .clock_in(clock_in),
    .reset_n_in(reset_n_in),
    .pixel_write_enable(pixel_write_enable),
    .pixel_write_address(pixel_write_address),
    .pixel_write_data(pixel_write_data),
    .read_enable(read_enable),
    .read_address(read_address),
    .pixel_data(pixel_data),
    .pixel_valid(pixel_valid),
    .swap_request(swap_request)
);

endmodule

//--- logic/display_scan.sv
/*
 * Raster scanner for the frame store. Blanks, then streams every pixel address
 * of one frame with read_enable high and a frame_start pulse on the first one
 */

`timescale 1ns/1ps

module display_scan #(
    parameter int FRAME_WIDTH = 640,
    parameter int FRAME_HEIGHT = 400,
    parameter int PIXEL_ADDRESS_WIDTH = 18,
    parameter int BLANK_CYCLES = 1000
) (
    input logic clock_in,
    input logic reset_n_in,

    input logic scan_enable,

    output logic [PIXEL_ADDRESS_WIDTH-1:0] read_address,
    output logic read_enable,
    output logic frame_start
);

localparam int FRAME_PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
localparam int BLANK_COUNT_WIDTH = $clog2(BLANK_CYCLES + 1);

display_pkg::scan_state_t scan_state;
logic [BLANK_COUNT_WIDTH-1:0] blank_count;
logic last_blank_cycle;
logic last_pixel;

assign last_blank_cycle = blank_count == BLANK_COUNT_WIDTH'(BLANK_CYCLES - 1);
assign last_pixel = read_address == PIXEL_ADDRESS_WIDTH'(FRAME_PIXELS - 1);
assign read_enable = scan_state == display_pkg::SCAN_ACTIVE;

always_ff @(posedge clock_in) begin
    if (reset_n_in == 0) begin
        scan_state <= display_pkg::SCAN_BLANK;
        blank_count <= '0;
        read_address <= '0;
        frame_start <= 0;
    end else begin
        frame_start <= 0;

        case (scan_state)
            display_pkg::SCAN_BLANK: begin
                // Stays in blanking while the scanner is held off
                if (scan_enable) begin
                    if (last_blank_cycle) begin
                        scan_state <= display_pkg::SCAN_ACTIVE;
                        blank_count <= '0;
                        frame_start <= 1;
                    end else begin
                        blank_count <= blank_count + 1'b1;
                    end
                end
            end

            display_pkg::SCAN_ACTIVE: begin
                // Address rests at zero for the next frame
                if (last_pixel) begin
                    scan_state <= display_pkg::SCAN_BLANK;
                    read_address <= '0;
                end else begin
                    read_address <= read_address + 1'b1;
                end
            end

            default: begin
                scan_state <= display_pkg::SCAN_BLANK;
            end
        endcase
    end
end

address_in_frame : assert property (
    @(posedge clock_in) disable iff (!reset_n_in)
    read_enable |-> read_address < FRAME_PIXELS
);

endmodule

//--- logic/display_buffers.sv
/*
 * Double-buffered 4-bit pixel store. Writes go to the back buffer through a
 * read-modify-write pipeline, reads stream from the front buffer in two cycles
 */

`timescale 1ns/1ps

module display_buffers #(
    parameter int PIXEL_ADDRESS_WIDTH = 18
) (
    input logic clock_in,
    input logic reset_n_in,

    input logic pixel_write_enable,
    input logic [PIXEL_ADDRESS_WIDTH-1:0] pixel_write_address,
    input logic [display_pkg::PIXEL_BITS-1:0] pixel_write_data,

    input logic read_enable,
    input logic [PIXEL_ADDRESS_WIDTH-1:0] read_address,
    output logic [display_pkg::PIXEL_BITS-1:0] pixel_data,
    output logic pixel_valid,

    input logic swap_request
);

// Address layout is {half, word, nibble}, the top bit picks the bank half
localparam int NIBBLE_BITS = $clog2(display_pkg::PIXELS_PER_WORD);
localparam int WORD_ADDRESS_WIDTH = PIXEL_ADDRESS_WIDTH - 1 - NIBBLE_BITS;
localparam int BANK_WORDS = 2 ** WORD_ADDRESS_WIDTH;

display_pkg::buffer_select_t displayed_buffer;
logic [1:0] swap_edge_monitor;
logic swap_pending;

// Banks indexed by {buffer, half}: A top, A bottom, B top, B bottom
logic [display_pkg::WORD_BITS-1:0] bank_read_data [4];
logic [3:0] bank_write_enable;
logic [WORD_ADDRESS_WIDTH-1:0] buffer_a_read_address;
logic [WORD_ADDRESS_WIDTH-1:0] buffer_b_read_address;

// Write stage 1, the old word is being read
logic write_pending;
display_pkg::buffer_select_t write_buffer;
logic [PIXEL_ADDRESS_WIDTH-1:0] write_address;
logic [display_pkg::PIXEL_BITS-1:0] write_data;
logic [1:0] write_bank;
logic [WORD_ADDRESS_WIDTH-1:0] write_word_address;

// Write stage 2, copy of the word written last cycle
logic last_valid;
display_pkg::buffer_select_t last_buffer;
logic [PIXEL_ADDRESS_WIDTH-NIBBLE_BITS-1:0] last_word_address;
logic [display_pkg::WORD_BITS-1:0] last_word;

logic forward_hit;
logic [display_pkg::WORD_BITS-1:0] source_word;
logic [display_pkg::WORD_BITS-1:0] merged_word;

// Read side
logic read_valid_q;
display_pkg::buffer_select_t read_buffer_q;
logic read_half_q;
logic [NIBBLE_BITS-1:0] read_nibble_q;
logic [display_pkg::WORD_BITS-1:0] read_word;

// Swap control
always_ff @(posedge clock_in) begin
    if (reset_n_in == 0) begin
        displayed_buffer <= display_pkg::BUFFER_A;
        swap_edge_monitor <= '0;
        swap_pending <= 0;
    end else begin
        swap_edge_monitor <= {swap_edge_monitor[0], swap_request};

        // Only flip while the scanner is in blanking
        if (swap_pending && !read_enable) begin
            displayed_buffer <= (displayed_buffer == display_pkg::BUFFER_A) ?
                                display_pkg::BUFFER_B : display_pkg::BUFFER_A;
            swap_pending <= 0;
        end

        // A fresh request edge is never dropped
        if (swap_edge_monitor == 2'b01) begin
            swap_pending <= 1;
        end
    end
end

// Front pair follows the scanner, back pair reads the word about to be merged
always_comb begin
    if (displayed_buffer == display_pkg::BUFFER_A) begin
        buffer_a_read_address = read_address[PIXEL_ADDRESS_WIDTH-2:NIBBLE_BITS];
        buffer_b_read_address = pixel_write_address[PIXEL_ADDRESS_WIDTH-2:NIBBLE_BITS];
    end else begin
        buffer_a_read_address = pixel_write_address[PIXEL_ADDRESS_WIDTH-2:NIBBLE_BITS];
        buffer_b_read_address = read_address[PIXEL_ADDRESS_WIDTH-2:NIBBLE_BITS];
    end
end

always_ff @(posedge clock_in) begin
    if (reset_n_in == 0) begin
        write_pending <= 0;
        last_valid <= 0;
    end else begin
        write_pending <= pixel_write_enable;
        last_valid <= write_pending;
    end
end

always_ff @(posedge clock_in) begin
    // Target is whichever buffer is off screen when the write arrives
    write_buffer <= (displayed_buffer == display_pkg::BUFFER_A) ?
                    display_pkg::BUFFER_B : display_pkg::BUFFER_A;
    write_address <= pixel_write_address;
    write_data <= pixel_write_data;

    last_buffer <= write_buffer;
    last_word_address <= write_address[PIXEL_ADDRESS_WIDTH-1:NIBBLE_BITS];
    last_word <= merged_word;
end

assign write_bank = {write_buffer, write_address[PIXEL_ADDRESS_WIDTH-1]};
assign write_word_address = write_address[PIXEL_ADDRESS_WIDTH-2:NIBBLE_BITS];

always_comb begin
    // RAM still holds the stale word when the previous write hit the same one
    forward_hit = last_valid && (last_buffer == write_buffer) &&
                  (last_word_address == write_address[PIXEL_ADDRESS_WIDTH-1:NIBBLE_BITS]);
    source_word = forward_hit ? last_word : bank_read_data[write_bank];

    merged_word = source_word;
    merged_word[write_address[NIBBLE_BITS-1:0] * display_pkg::PIXEL_BITS +:
                display_pkg::PIXEL_BITS] = write_data;

    bank_write_enable = '0;
    if (write_pending) begin
        bank_write_enable[write_bank] = 1'b1;
    end
end

pixel_ram_bank #(.BANK_WORDS(BANK_WORDS)) buffer_a_top (
    .clock_in(clock_in),
    .write_enable(bank_write_enable[0]),
    .write_address(write_word_address),
    .write_data(merged_word),
    .read_address(buffer_a_read_address),
    .read_data(bank_read_data[0])
);

pixel_ram_bank #(.BANK_WORDS(BANK_WORDS)) buffer_a_bottom (
    .clock_in(clock_in),
    .write_enable(bank_write_enable[1]),
    .write_address(write_word_address),
    .write_data(merged_word),
    .read_address(buffer_a_read_address),
    .read_data(bank_read_data[1])
);

pixel_ram_bank #(.BANK_WORDS(BANK_WORDS)) buffer_b_top (
    .clock_in(clock_in),
    .write_enable(bank_write_enable[2]),
    .write_address(write_word_address),
    .write_data(merged_word),
    .read_address(buffer_b_read_address),
    .read_data(bank_read_data[2])
);

pixel_ram_bank #(.BANK_WORDS(BANK_WORDS)) buffer_b_bottom (
    .clock_in(clock_in),
    .write_enable(bank_write_enable[3]),
    .write_address(write_word_address),
    .write_data(merged_word),
    .read_address(buffer_b_read_address),
    .read_data(bank_read_data[3])
);

always_ff @(posedge clock_in) begin
    if (reset_n_in == 0) begin
        read_valid_q <= 0;
        pixel_valid <= 0;
    end else begin
        read_valid_q <= read_enable;
        pixel_valid <= read_valid_q;
    end
end

// Select follows the word through the RAM latency, so a swap never splits a read
always_ff @(posedge clock_in) begin
    read_buffer_q <= displayed_buffer;
    read_half_q <= read_address[PIXEL_ADDRESS_WIDTH-1];
    read_nibble_q <= read_address[NIBBLE_BITS-1:0];
    pixel_data <= read_word[read_nibble_q * display_pkg::PIXEL_BITS +: display_pkg::PIXEL_BITS];
end

assign read_word = bank_read_data[{read_buffer_q, read_half_q}];

one_bank_written : assert property (
    @(posedge clock_in) disable iff (!reset_n_in) $onehot0(bank_write_enable)
);

// Pending swap waits out the active region of the scanner
swap_held_while_active : assert property (
    @(posedge clock_in) disable iff (!reset_n_in)
    swap_pending && read_enable |=> swap_pending
);

endmodule

//--- logic/pixel_ram_bank.sv
/*
 * Simple dual-port frame store bank with one write port and a registered read.
 * Behavioral stand-in for a vendor block RAM, four of them make the double buffer
 */

`timescale 1ns/1ps

module pixel_ram_bank #(
    parameter int BANK_WORDS = 16384
) (
    input logic clock_in,

    input logic write_enable,
    input logic [$clog2(BANK_WORDS)-1:0] write_address,
    input logic [display_pkg::WORD_BITS-1:0] write_data,

    input logic [$clog2(BANK_WORDS)-1:0] read_address,
    output logic [display_pkg::WORD_BITS-1:0] read_data
);

logic [display_pkg::WORD_BITS-1:0] memory [BANK_WORDS];

// Read returns the old word when both ports hit the same address
always_ff @(posedge clock_in) begin
    if (write_enable) begin
        memory[write_address] <= write_data;
    end

    read_data <= memory[read_address];
end

endmodule

//--- logic/display_pkg.sv
/*
 * Pixel packing constants and state types shared by the frame store RTL.
 * Referenced by scoped name from the modules and the testbench
 */
package display_pkg;

// Each RAM word packs eight 4-bit pixels, pixel 0 in the low nibble
localparam int PIXEL_BITS = 4;
localparam int PIXELS_PER_WORD = 8;
localparam int WORD_BITS = PIXEL_BITS * PIXELS_PER_WORD;

// Buffer currently on display, the other one takes writes
typedef enum logic {
    BUFFER_A,
    BUFFER_B
} buffer_select_t;

// Scanner phase
typedef enum logic {
    SCAN_BLANK,
    SCAN_ACTIVE
} scan_state_t;

endpackage
